// ==== design/decode_params.svh ====
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// instruction slots per fetch packet
`define DECODE_WIDTH 2

// architectural register id width, 32 GPRs
`define ARF_ID_W 5

`endif

// ==== design/isa_pkg.sv ====
package isa_pkg;

    // register-format view: 17-bit opcode, then rk, rj, rd
    typedef struct packed {
        logic [16:0] op_hi;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_reg_view_t;

    // immediate-format view, as used by lu12i.w
    typedef struct packed {
        logic [6:0]  op_hi;
        logic [19:0] imm20;
        logic [4:0]  imm5;
    } inst_imm_view_t;

    typedef union packed {
        inst_reg_view_t reg_f;
        inst_imm_view_t imm_f;
    } inst_word_u;

    typedef enum logic [2:0] {
        REG_ZERO = 3'd0,
        REG_RD   = 3'd1,
        REG_RJ   = 3'd2,
        REG_RK   = 3'd3,
        REG_IMM  = 3'd4
    } reg_sel_t;

    typedef enum logic [1:0] {
        W_NONE = 2'd0,
        W_RD   = 2'd1,
        W_RJ   = 2'd2,
        W_R1   = 2'd3
    } reg_w_sel_t;

    typedef enum logic [1:0] {IMM_S12, IMM_S20, IMM_U5, IMM_U12} imm_type_t;
    typedef enum logic [1:0] {ADDR_S12, ADDR_S16, ADDR_S26} addr_imm_type_t;
    typedef enum logic [1:0] {UNIT_ALU, UNIT_LSU, UNIT_BR} unit_type_t;
    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_LUI} alu_op_t;
    typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_B, BR_BL} br_type_t;

    // memory access size, log2 of bytes
    localparam logic [1:0] MSIZE_WORD = 2'd2;

    // opcode patterns, grouped by how many top bits they occupy
    localparam logic [16:0] OP17_ADD_W  = 17'h00020;
    localparam logic [16:0] OP17_SUB_W  = 17'h00022;
    localparam logic [16:0] OP17_AND    = 17'h00029;
    localparam logic [16:0] OP17_OR     = 17'h0002a;
    localparam logic [16:0] OP17_SLLI_W = 17'h00081;
    localparam logic [9:0]  OP10_ADDI_W = 10'h00a;
    localparam logic [9:0]  OP10_ANDI   = 10'h00d;
    localparam logic [9:0]  OP10_LD_W   = 10'h0a2;
    localparam logic [9:0]  OP10_ST_W   = 10'h0a6;
    localparam logic [6:0]  OP7_LU12I_W = 7'h0a;
    localparam logic [5:0]  OP6_B       = 6'h14;
    localparam logic [5:0]  OP6_BL      = 6'h15;
    localparam logic [5:0]  OP6_BEQ     = 6'h16;
    localparam logic [5:0]  OP6_BNE     = 6'h17;

    typedef struct packed {
        reg_sel_t       reg_r0;
        reg_sel_t       reg_r1;
        reg_w_sel_t     reg_w;
        imm_type_t      imm_type;
        addr_imm_type_t addr_imm_type;
        unit_type_t     unit;
        alu_op_t        alu_op;
        br_type_t       br_type;
        logic           mem_write;
        logic [1:0]     mem_size;
        logic           decode_err;
        inst_word_u     inst;
    } decode_info_t;

endpackage

// ==== design/pipe_pkg.sv ====
`include "decode_params.svh"

package pipe_pkg;

    import isa_pkg::*;

    // fetch to decode
    typedef struct packed {
        logic [`DECODE_WIDTH-1:0]             mask;
        logic [31:0]                          pc;
        inst_word_u [`DECODE_WIDTH-1:0]       insts;
    } f_d_pkg_t;

    // decode to rename, two read ports and one write port per slot
    typedef struct packed {
        logic [`DECODE_WIDTH-1:0]                     r_valid;
        logic [`DECODE_WIDTH-1:0][31:0]               pc;
        logic [`DECODE_WIDTH-1:0]                     w_reg;
        logic [`DECODE_WIDTH-1:0]                     w_mem;
        logic [2*`DECODE_WIDTH-1:0]                   reg_need;
        logic [2*`DECODE_WIDTH-1:0]                   use_imm;
        logic [2*`DECODE_WIDTH-1:0][`ARF_ID_W-1:0]    r_arfid;
        logic [`DECODE_WIDTH-1:0][`ARF_ID_W-1:0]      w_arfid;
        logic [`DECODE_WIDTH-1:0][31:0]               data_imm;
        logic [`DECODE_WIDTH-1:0][31:0]               addr_imm;
        unit_type_t [`DECODE_WIDTH-1:0]               unit;
        alu_op_t [`DECODE_WIDTH-1:0]                  op;
        logic [`DECODE_WIDTH-1:0][1:0]                msize;
        br_type_t [`DECODE_WIDTH-1:0]                 br_type;
        logic [`DECODE_WIDTH-1:0]                     decode_err;
        logic [`DECODE_WIDTH-1:0][4:0]                inst_4_0;
    } d_r_pkg_t;

endpackage

// ==== design/basic_decoder.sv ====
module basic_decoder (
    input  isa_pkg::inst_word_u   inst,
    output isa_pkg::decode_info_t info
);

    import isa_pkg::*;

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;

    // opcode prefixes of different lengths, all taken from the top of the word
    assign op17 = inst.reg_f.op_hi;
    assign op10 = inst.reg_f.op_hi[16:7];
    assign op7  = inst.imm_f.op_hi;
    assign op6  = inst.imm_f.op_hi[6:1];

    always_comb begin
        info = '0;
        info.inst = inst;
        if (op17 == OP17_ADD_W || op17 == OP17_SUB_W || op17 == OP17_AND || op17 == OP17_OR) begin
            info.reg_r0 = REG_RJ;
            info.reg_r1 = REG_RK;
            info.reg_w  = W_RD;
            info.unit   = UNIT_ALU;
            case (op17)
                OP17_SUB_W: info.alu_op = ALU_SUB;
                OP17_AND:   info.alu_op = ALU_AND;
                OP17_OR:    info.alu_op = ALU_OR;
                default:    info.alu_op = ALU_ADD;
            endcase
        end else if (op17 == OP17_SLLI_W) begin
            // shift amount sits in the rk field
            info.reg_r0   = REG_RJ;
            info.reg_r1   = REG_IMM;
            info.reg_w    = W_RD;
            info.imm_type = IMM_U5;
            info.alu_op   = ALU_SLL;
        end else if (op10 == OP10_ADDI_W || op10 == OP10_ANDI) begin
            info.reg_r0   = REG_RJ;
            info.reg_r1   = REG_IMM;
            info.reg_w    = W_RD;
            info.imm_type = (op10 == OP10_ANDI) ? IMM_U12 : IMM_S12;
            info.alu_op   = (op10 == OP10_ANDI) ? ALU_AND : ALU_ADD;
        end else if (op7 == OP7_LU12I_W) begin
            info.reg_r1   = REG_IMM;
            info.reg_w    = W_RD;
            info.imm_type = IMM_S20;
            info.alu_op   = ALU_LUI;
        end else if (op10 == OP10_LD_W || op10 == OP10_ST_W) begin
            info.reg_r0   = REG_RJ;
            info.unit     = UNIT_LSU;
            info.mem_size = MSIZE_WORD;
            // store data comes from rd, load result goes to rd
            if (op10 == OP10_ST_W) begin
                info.reg_r1    = REG_RD;
                info.mem_write = 1'b1;
            end else begin
                info.reg_w = W_RD;
            end
        end else if (op6 == OP6_BEQ || op6 == OP6_BNE) begin
            info.reg_r0        = REG_RJ;
            info.reg_r1        = REG_RD;
            info.addr_imm_type = ADDR_S16;
            info.unit          = UNIT_BR;
            info.br_type       = (op6 == OP6_BEQ) ? BR_BEQ : BR_BNE;
        end else if (op6 == OP6_B || op6 == OP6_BL) begin
            info.addr_imm_type = ADDR_S26;
            info.unit          = UNIT_BR;
            info.br_type       = (op6 == OP6_BL) ? BR_BL : BR_B;
            // link register is r1
            info.reg_w         = (op6 == OP6_BL) ? W_R1 : W_NONE;
        end else begin
            info.decode_err = 1'b1;
        end
    end

endmodule

// ==== design/imm_extract.sv ====
module imm_extract (
    input  isa_pkg::inst_word_u     inst,
    input  isa_pkg::imm_type_t      imm_type,
    input  isa_pkg::addr_imm_type_t addr_imm_type,
    output logic [31:0]             data_imm,
    output logic [31:0]             addr_imm
);

    import isa_pkg::*;

    logic [31:0] w;

    assign w = inst;

    // operand immediates for the alu
    always_comb begin
        case (imm_type)
            IMM_S12: data_imm = {{20{w[21]}}, w[21:10]};
            IMM_S20: data_imm = {{12{inst.imm_f.imm20[19]}}, inst.imm_f.imm20};
            IMM_U5:  data_imm = {27'b0, w[14:10]};
            default: data_imm = {20'b0, w[21:10]};
        endcase
    end

    // address offsets, branch offsets are in words
    always_comb begin
        case (addr_imm_type)
            ADDR_S12: addr_imm = {{20{w[21]}}, w[21:10]};
            ADDR_S16: addr_imm = {{14{w[25]}}, w[25:10], 2'b00};
            default:  addr_imm = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        endcase
    end

endmodule

// ==== design/decoder.sv ====
`include "decode_params.svh"

module decoder (
    input  pipe_pkg::f_d_pkg_t head_pkt,
    output pipe_pkg::d_r_pkg_t out_pkt
);

    import isa_pkg::*;
    import pipe_pkg::*;

    decode_info_t infos    [`DECODE_WIDTH];
    logic [31:0]  data_imms[`DECODE_WIDTH];
    logic [31:0]  addr_imms[`DECODE_WIDTH];

    // zero and immediate operands read r0
    function automatic logic [`ARF_ID_W-1:0] read_id(input reg_sel_t sel, input inst_word_u w);
        case (sel)
            REG_RD:  return w.reg_f.rd;
            REG_RJ:  return w.reg_f.rj;
            REG_RK:  return w.reg_f.rk;
            default: return '0;
        endcase
    endfunction

    function automatic logic [`ARF_ID_W-1:0] write_id(input reg_w_sel_t sel, input inst_word_u w);
        case (sel)
            W_RD:    return w.reg_f.rd;
            W_RJ:    return w.reg_f.rj;
            W_R1:    return `ARF_ID_W'(1);
            default: return '0;
        endcase
    endfunction

    for (genvar s = 0; s < `DECODE_WIDTH; s++) begin : g_slot
        basic_decoder basic_decoder_inst (
            .inst (head_pkt.insts[s]),
            .info (infos[s])
        );

        imm_extract imm_extract_inst (
            .inst          (head_pkt.insts[s]),
            .imm_type      (infos[s].imm_type),
            .addr_imm_type (infos[s].addr_imm_type),
            .data_imm      (data_imms[s]),
            .addr_imm      (addr_imms[s])
        );
    end

    always_comb begin
        out_pkt.r_valid = head_pkt.mask;
        for (int s = 0; s < `DECODE_WIDTH; s++) begin
            // packets are aligned, so each slot pc just sets its word offset
            out_pkt.pc[s]           = head_pkt.pc | (32'(s) << 2);
            out_pkt.w_reg[s]        = infos[s].reg_w != W_NONE;
            out_pkt.w_mem[s]        = infos[s].mem_write;
            out_pkt.reg_need[2*s]   = !(infos[s].reg_r0 inside {REG_ZERO, REG_IMM});
            out_pkt.reg_need[2*s+1] = !(infos[s].reg_r1 inside {REG_ZERO, REG_IMM});
            out_pkt.use_imm[2*s]    = infos[s].reg_r0 == REG_IMM;
            out_pkt.use_imm[2*s+1]  = infos[s].reg_r1 == REG_IMM;
            out_pkt.r_arfid[2*s]    = read_id(infos[s].reg_r0, infos[s].inst);
            out_pkt.r_arfid[2*s+1]  = read_id(infos[s].reg_r1, infos[s].inst);
            out_pkt.w_arfid[s]      = write_id(infos[s].reg_w, infos[s].inst);
            out_pkt.data_imm[s]     = data_imms[s];
            out_pkt.addr_imm[s]     = addr_imms[s];
            out_pkt.unit[s]         = infos[s].unit;
            out_pkt.op[s]           = infos[s].alu_op;
            out_pkt.msize[s]        = infos[s].mem_size;
            out_pkt.br_type[s]      = infos[s].br_type;
            out_pkt.decode_err[s]   = infos[s].decode_err;
            out_pkt.inst_4_0[s]     = infos[s].inst.reg_f.rd;
        end
    end

endmodule

// ==== design/decode_fifo.sv ====
module decode_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push_valid,
    output logic               push_ready,
    input  pipe_pkg::f_d_pkg_t push_pkt,
    output logic               head_valid,
    input  logic               pop,
    output pipe_pkg::f_d_pkg_t head_pkt
);

    import pipe_pkg::*;

    f_d_pkg_t   entries[2];
    logic       rd_ptr;
    logic       wr_ptr;
    logic [1:0] count;
    logic       do_push;
    logic       do_pop;

    assign head_valid = count != 2'd0;
    // a full queue still takes a packet when the head leaves this cycle
    assign push_ready = (count != 2'd2) || pop;
    assign do_pop     = pop && head_valid;
    assign do_push    = push_valid && push_ready;
    assign head_pkt   = entries[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= 1'b0;
            wr_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (do_push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (do_pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_pkt;
        end
    end

endmodule

// ==== design/decode_stage.sv ====
module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  pipe_pkg::f_d_pkg_t in_pkt,
    output logic               out_valid,
    input  logic               out_ready,
    output pipe_pkg::d_r_pkg_t out_pkt
);

    import pipe_pkg::*;

    f_d_pkg_t head_pkt;

    // the queue is the only register in this stage
    decode_fifo decode_fifo_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (in_valid),
        .push_ready (in_ready),
        .push_pkt   (in_pkt),
        .head_valid (out_valid),
        .pop        (out_valid && out_ready),
        .head_pkt   (head_pkt)
    );

    decoder decoder_inst (
        .head_pkt (head_pkt),
        .out_pkt  (out_pkt)
    );

endmodule

// ==== testbench/decode_stage_props.sv ====
`include "decode_params.svh"

module decode_stage_props (
    input logic               clk,
    input logic               rst_n,
    input logic               in_valid,
    input logic               in_ready,
    input logic               out_valid,
    input logic               out_ready,
    input pipe_pkg::f_d_pkg_t head_pkt,
    input pipe_pkg::d_r_pkg_t out_pkt
);

    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;

    // expected decode of one slot
    typedef struct packed {
        logic [`ARF_ID_W-1:0] r0;
        logic [`ARF_ID_W-1:0] r1;
        logic [`ARF_ID_W-1:0] wid;
        logic [1:0]           need;
        logic [1:0]           imm;
        logic                 wreg;
        logic                 wmem;
        logic                 err;
        logic                 chk_d;
        logic                 chk_a;
        logic [31:0]          dimm;
        logic [31:0]          aimm;
        logic [1:0]           unit;
        logic [2:0]           op;
        logic [1:0]           msize;
        logic [2:0]           br;
        logic [4:0]           low5;
    } slot_exp_t;

    logic [1:0]  held;
    int unsigned fails = 0;

    function automatic slot_exp_t rule_decode(input logic [31:0] w);
        slot_exp_t  e;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        e      = '0;
        rd     = w[4:0];
        rj     = w[9:5];
        rk     = w[14:10];
        e.low5 = w[4:0];
        if (w[31:15] inside {17'h20, 17'h22, 17'h29, 17'h2a}) begin
            {e.r0, e.r1, e.wid, e.need, e.wreg} = {rj, rk, rd, 2'b11, 1'b1};
            case (w[31:15])
                17'h20:  e.op = ALU_ADD;
                17'h22:  e.op = ALU_SUB;
                17'h29:  e.op = ALU_AND;
                default: e.op = ALU_OR;
            endcase
        end else if (w[31:15] == 17'h81) begin
            // slli.w takes its shift amount from the rk field
            {e.r0, e.wid, e.need, e.imm, e.wreg} = {rj, rd, 2'b01, 2'b10, 1'b1};
            e.chk_d = 1'b1;
            e.dimm  = {27'b0, w[14:10]};
            e.op    = ALU_SLL;
        end else if (w[31:22] == 10'h00a || w[31:22] == 10'h00d) begin
            {e.r0, e.wid, e.need, e.imm, e.wreg} = {rj, rd, 2'b01, 2'b10, 1'b1};
            e.chk_d = 1'b1;
            // andi zero-extends, addi.w sign-extends
            e.dimm  = w[22] ? {20'b0, w[21:10]} : {{20{w[21]}}, w[21:10]};
            e.op    = w[22] ? ALU_AND : ALU_ADD;
        end else if (w[31:25] == 7'h0a) begin
            {e.wid, e.imm, e.wreg, e.chk_d} = {rd, 2'b10, 1'b1, 1'b1};
            e.dimm = {{12{w[24]}}, w[24:5]};
            e.op   = ALU_LUI;
        end else if (w[31:22] == 10'h0a2 || w[31:22] == 10'h0a6) begin
            {e.r0, e.chk_a} = {rj, 1'b1};
            e.aimm  = {{20{w[21]}}, w[21:10]};
            e.unit  = UNIT_LSU;
            e.msize = MSIZE_WORD;
            if (w[31:22] == 10'h0a6) begin
                {e.r1, e.need, e.wmem} = {rd, 2'b11, 1'b1};
            end else begin
                {e.wid, e.need, e.wreg} = {rd, 2'b01, 1'b1};
            end
        end else if (w[31:26] == 6'h16 || w[31:26] == 6'h17) begin
            {e.r0, e.r1, e.need, e.chk_a} = {rj, rd, 2'b11, 1'b1};
            e.aimm = {{14{w[25]}}, w[25:10], 2'b00};
            e.unit = UNIT_BR;
            e.br   = w[26] ? BR_BNE : BR_BEQ;
        end else if (w[31:26] == 6'h14 || w[31:26] == 6'h15) begin
            e.chk_a = 1'b1;
            e.aimm  = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            e.unit  = UNIT_BR;
            e.br    = BR_B;
            // bl links through r1
            if (w[26]) begin
                {e.wid, e.wreg} = {5'd1, 1'b1};
                e.br = BR_BL;
            end
        end else begin
            e.err = 1'b1;
        end
        return e;
    endfunction

    // queue occupancy from the handshakes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= 2'd0;
        end else begin
            held <= held + 2'(in_valid && in_ready) - 2'(out_valid && out_ready);
        end
    end

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid && in_ready)
        else begin
            $error("outputs not idle while reset is asserted");
            fails++;
        end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_pkt))
        else begin
            $error("output packet changed while stalled");
            fails++;
        end

    a_ready_full: assert property (@(posedge clk) disable iff (!rst_n)
        !in_ready == (held == 2'd2 && !out_ready))
        else begin
            $error("in_ready does not follow queue occupancy %0d", held);
            fails++;
        end

    for (genvar s = 0; s < `DECODE_WIDTH; s++) begin : g_slot
        slot_exp_t exp_slot;

        assign exp_slot = rule_decode(head_pkt.insts[s]);

        a_reg_ids: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid |-> out_pkt.r_arfid[2*s] == exp_slot.r0
                && out_pkt.r_arfid[2*s+1] == exp_slot.r1
                && out_pkt.w_arfid[s] == exp_slot.wid)
            else begin
                $error("slot %0d register ids wrong for word %h", s, head_pkt.insts[s]);
                fails++;
            end

        a_flags: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid |-> out_pkt.reg_need[2*s +: 2] == exp_slot.need
                && out_pkt.use_imm[2*s +: 2] == exp_slot.imm
                && out_pkt.w_reg[s] == exp_slot.wreg
                && out_pkt.w_mem[s] == exp_slot.wmem
                && out_pkt.decode_err[s] == exp_slot.err)
            else begin
                $error("slot %0d control flags wrong for word %h", s, head_pkt.insts[s]);
                fails++;
            end

        a_imms: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid |-> (!exp_slot.chk_d || out_pkt.data_imm[s] == exp_slot.dimm)
                && (!exp_slot.chk_a || out_pkt.addr_imm[s] == exp_slot.aimm))
            else begin
                $error("slot %0d immediates wrong for word %h", s, head_pkt.insts[s]);
                fails++;
            end

        // alu op only matters for the alu, size only for the lsu
        a_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid |-> out_pkt.unit[s] == exp_slot.unit
                && (exp_slot.unit != UNIT_ALU || out_pkt.op[s] == exp_slot.op)
                && (exp_slot.unit != UNIT_LSU || out_pkt.msize[s] == exp_slot.msize)
                && out_pkt.br_type[s] == exp_slot.br
                && out_pkt.inst_4_0[s] == exp_slot.low5)
            else begin
                $error("slot %0d unit or op fields wrong for word %h", s, head_pkt.insts[s]);
                fails++;
            end
    end

endmodule

bind decode_stage decode_stage_props decode_stage_props_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .head_pkt  (head_pkt),
    .out_pkt   (out_pkt)
);

// ==== testbench/tb_decode_stage.sv ====
`include "decode_params.svh"

module tb_decode_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import pipe_pkg::*;

    localparam int NUM_PKTS    = 300;
    localparam int DRAIN_LIMIT = 5000;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    logic     in_ready;
    f_d_pkg_t in_pkt;
    logic     out_valid;
    logic     out_ready;
    d_r_pkg_t out_pkt;

    // subset opcodes in order add.w .. bne, then two illegal patterns
    logic [31:0] op_base [16] = '{
        32'h0010_0000, 32'h0011_0000, 32'h0014_8000, 32'h0015_0000,
        32'h0040_8000, 32'h0280_0000, 32'h0340_0000, 32'h2880_0000,
        32'h2980_0000, 32'h1400_0000, 32'h5000_0000, 32'h5400_0000,
        32'h5800_0000, 32'h5c00_0000, 32'hfc00_0000, 32'h0000_0000
    };
    // bits below each opcode, filled at random
    logic [31:0] field_mask [16] = '{
        32'h0000_7fff, 32'h0000_7fff, 32'h0000_7fff, 32'h0000_7fff,
        32'h0000_7fff, 32'h003f_ffff, 32'h003f_ffff, 32'h003f_ffff,
        32'h003f_ffff, 32'h01ff_ffff, 32'h03ff_ffff, 32'h03ff_ffff,
        32'h03ff_ffff, 32'h03ff_ffff, 32'h03ff_ffff, 32'h0000_7fff
    };

    f_d_pkg_t sb[$];
    int       sent;
    int       seen;
    int       errors;
    int       burst_left;

    decode_stage decode_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] random_word();
        int idx;
        idx = $urandom_range(15);
        return op_base[idx] | ($urandom & field_mask[idx]);
    endfunction

    function automatic f_d_pkg_t random_pkt();
        f_d_pkg_t p;
        p.mask     = 2'($urandom_range(1, 3));
        p.pc       = $urandom & 32'hffff_fff8;
        p.insts[0] = random_word();
        p.insts[1] = random_word();
        return p;
    endfunction

    task automatic check_output(input f_d_pkg_t exp);
        seen++;
        if (out_pkt.pc[0] !== exp.pc || out_pkt.pc[1] !== (exp.pc | 32'h4)
                || out_pkt.r_valid !== exp.mask) begin
            errors++;
            $display("MISMATCH at %0t: packet %0d pc %h/%h mask %b, expected pc %h mask %b",
                     $time, seen, out_pkt.pc[0], out_pkt.pc[1], out_pkt.r_valid,
                     exp.pc, exp.mask);
        end
    endtask

    task automatic report_and_finish(input bit timed_out);
        int assert_fails;
        assert_fails = decode_stage_inst.decode_stage_props_inst.fails;
        $display("errors: scoreboard %0d, assertions %0d, timeouts %0d",
                 errors, assert_fails, timed_out);
        if (!timed_out && errors == 0 && assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // scoreboard first, then new stimulus for the next cycle
    always @(posedge clk) begin
        if (rst_n) begin
            if (out_valid !== (sb.size() != 0)) begin
                errors++;
                $display("MISMATCH at %0t: out_valid %b with %0d packets pending",
                         $time, out_valid, sb.size());
            end
            if (out_valid && out_ready && sb.size() != 0) begin
                check_output(sb.pop_front());
            end
            if (in_valid && in_ready) begin
                sb.push_back(in_pkt);
                sent++;
            end
            // hold the packet while the queue is full
            if (!in_valid || in_ready) begin
                in_valid <= sent < NUM_PKTS && $urandom_range(3) != 0;
                in_pkt   <= random_pkt();
            end
            if (burst_left == 0) begin
                out_ready  <= !out_ready;
                burst_left = $urandom_range(1, 8);
            end else begin
                burst_left--;
            end
        end
    end

    initial begin
        int cycles;
        void'($urandom(65));
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_pkt     = '0;
        out_ready  = 1'b0;
        sent       = 0;
        seen       = 0;
        errors     = 0;
        burst_left = 0;
        cycles     = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        while (seen < NUM_PKTS && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (seen < NUM_PKTS) begin
            $display("timeout: only %0d of %0d packets left the DUT", seen, NUM_PKTS);
        end
        repeat (2) @(negedge clk);
        report_and_finish(seen < NUM_PKTS);
    end

endmodule

// ==== tb.f ====
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/basic_decoder.sv
design/imm_extract.sv
design/decoder.sv
design/decode_fifo.sv
design/decode_stage.sv
testbench/decode_stage_props.sv
testbench/tb_decode_stage.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_decode_stage
FILELIST  := tb.f
BUILD_DIR := build
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := design/decode_params.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
